/* camGrayAssertions.sv */
`timescale 1ns/1ps

module camGrayAssertions (
  input logic                s_systemClock,
  input logic                s_pllLocked,
  input logic                camnReset,
  input logic                grayWordValid,
  input logic                overflow,
  input logic                push,
  input camPkg::pixelEntry_t pushEntry
);

  noWordInCameraReset: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !camnReset |-> !grayWordValid
  ) else $error("word strobe while the camera is held in reset");

  noPushInCameraReset: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    push |-> camnReset
  ) else $error("pixel pushed before the camera left reset");

  // only a frame-start entry may clear the sticky flag
  overflowFallsOnFrameStart: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    $fell(overflow) |-> $past(push && pushEntry.frameStart)
  ) else $error("overflow cleared without a frame start push");

endmodule

/* camGrayTb.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module camGrayTb;

  localparam int CLOCK_PERIOD     = 20;
  localparam int DRIVE_DELAY      = 2;
  localparam int CYCLES_PER_PIXEL = 8;
  localparam int SETTLE_CYCLES    = 24;
  localparam int WORD_WAIT_LIMIT  = 200;
  localparam int WATCHDOG_MARGIN  = 1000;

  logic                       s_systemClock = 1'b0;
  logic                       s_pllLocked;
  logic                       camPclk;
  logic                       camHsync;
  logic                       camVsync;
  logic [`CAM_DATA_WIDTH-1:0] camData;
  logic                       captureEnable;
  logic                       camnReset;
  logic [`WORD_WIDTH-1:0]     grayWord;
  logic                       grayWordValid;
  logic                       overflow;

  logic [31:0]            golden [256];
  logic [`WORD_WIDTH-1:0] receivedWords [$];
  int wordsBeforeRelease = 0;
  int watchdogCycles = 0;
  int testErrors = 0;
  int errorCount = 0;
  int testsPassed = 0;
  int testsFailed = 0;

  camGrayTop UUT (.*);

  bind camGrayTop camGrayAssertions checks (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .camnReset(camnReset),
    .grayWordValid(grayWordValid),
    .overflow(overflow),
    .push(s_push),
    .pushEntry(s_pushEntry)
  );

  always #(CLOCK_PERIOD / 2) s_systemClock = ~s_systemClock;

  // words are strobed for one cycle, so the falling edge sees them settled
  always @(negedge s_systemClock) begin
    if (grayWordValid) begin
      if (!camnReset) wordsBeforeRelease++;
      receivedWords.push_back(grayWord);
    end
  end

  initial begin
    wait (watchdogCycles > 0);
    repeat (watchdogCycles) @(posedge s_systemClock);
    $display("watchdog expired before all tests finished");
    $display("sim failed");
    $finish;
  end

  task automatic nextDriveSlot();
    @(posedge s_systemClock);
    #DRIVE_DELAY;
  endtask

  // one camera clock period is four system cycles
  task automatic pclkCycle(input logic [`CAM_DATA_WIDTH-1:0] value);
    camData = value;
    camPclk = 1'b0;
    repeat (2) nextDriveSlot();
    camPclk = 1'b1;
    repeat (2) nextDriveSlot();
  endtask

  task automatic sendFrame(input int first, input int pixels);
    camVsync = 1'b1;
    repeat (2) pclkCycle('0);
    camVsync = 1'b0;
    pclkCycle('0);
    camHsync = 1'b1;
    for (int i = 0; i < pixels; i++) begin
      pclkCycle(golden[first + i][15:8]);
      pclkCycle(golden[first + i][7:0]);
    end
    camHsync = 1'b0;
    pclkCycle('0);
  endtask

  // *********************************************************
  task automatic runFrame(input int idx, input int pixels, input int words);
    int cycles;
    int firstWord;
    firstWord = idx + 5 + pixels;
    captureEnable = golden[idx + 1][0];
    sendFrame(idx + 5, pixels);
    if (!golden[idx + 1][0]) begin
      repeat (SETTLE_CYCLES) nextDriveSlot();
      captureEnable = 1'b1;
    end
    cycles = 0;
    while (receivedWords.size() < words && cycles < WORD_WAIT_LIMIT) begin
      nextDriveSlot();
      cycles++;
    end
    // extra words would show up within this window
    repeat (SETTLE_CYCLES) nextDriveSlot();
    if (receivedWords.size() != words) begin
      $display("expected %0d words but %0d arrived", words, receivedWords.size());
      testErrors++;
    end
    for (int w = 0; w < words && w < receivedWords.size(); w++) begin
      if (receivedWords[w] !== golden[firstWord + w]) begin
        $display("[FAIL] %0d ns: word %0d is %h, expected %h", $time, w,
                 receivedWords[w], golden[firstWord + w]);
        testErrors++;
      end
    end
    if (overflow !== golden[idx + 4][0]) begin
      $display("[FAIL] %0d ns: overflow is %b, expected %b", $time, overflow,
               golden[idx + 4][0]);
      testErrors++;
    end
    receivedWords.delete();
  endtask

  task automatic finishTest(input int test);
    if (testErrors == 0) begin
      $display("test %0d passed", test);
      testsPassed++;
    end else begin
      $display("test %0d failed with %0d errors", test, testErrors);
      testsFailed++;
    end
    errorCount += testErrors;
    testErrors = 0;
  endtask

  // *********************************************************
  initial begin
    int frameCount;
    int idx;
    int totalPixels;
    int test;
    int currentTest;
    int cycles;
    s_pllLocked   = 1'b0;
    camPclk       = 1'b0;
    camHsync      = 1'b0;
    camVsync      = 1'b0;
    camData       = '0;
    captureEnable = 1'b1;
    $readmemh("camera_golden.txt", golden);
    frameCount  = int'(golden[0]);
    idx         = 1;
    totalPixels = 0;
    for (int f = 0; f < frameCount; f++) begin
      totalPixels += int'(golden[idx + 2]);
      idx += 5 + int'(golden[idx + 2]) + int'(golden[idx + 3]);
    end
    watchdogCycles = 2 * totalPixels * CYCLES_PER_PIXEL + WATCHDOG_MARGIN;
    if (frameCount == 0) begin
      $display("the golden file holds no frames");
      testErrors++;
    end

    repeat (4) @(posedge s_systemClock);
    #DRIVE_DELAY;
    if (camnReset !== 1'b0) begin
      $display("[FAIL] %0d ns: camera released during PLL reset", $time);
      testErrors++;
    end
    s_pllLocked = 1'b1;
    camHsync    = 1'b1;
    cycles = 0;
    // the camera bus keeps toggling while its reset is still held
    while (camnReset !== 1'b1 && cycles < 100) begin
      camPclk = ~camPclk;
      camData = camData + 8'h35;
      nextDriveSlot();
      cycles++;
    end
    camHsync = 1'b0;
    camPclk  = 1'b0;
    if (cycles != 16) begin
      $display("[FAIL] %0d ns: camera released after %0d cycles, expected 16", $time, cycles);
      testErrors++;
    end
    if (wordsBeforeRelease != 0 || receivedWords.size() != 0) begin
      $display("a word appeared before the camera left reset");
      testErrors++;
    end
    finishTest(1);

    idx         = 1;
    currentTest = 0;
    for (int f = 0; f < frameCount; f++) begin
      test = int'(golden[idx]);
      if (test != currentTest && currentTest != 0) finishTest(currentTest);
      currentTest = test;
      runFrame(idx, int'(golden[idx + 2]), int'(golden[idx + 3]));
      idx += 5 + int'(golden[idx + 2]) + int'(golden[idx + 3]);
    end
    if (currentTest != 0) finishTest(currentTest);

    $display("tests passed %0d, tests failed %0d, errors %0d", testsPassed, testsFailed,
             errorCount);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* camGrayTop.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module camGrayTop (
  input  logic                       s_systemClock,
  input  logic                       s_pllLocked,
  input  logic                       camPclk,
  input  logic                       camHsync,
  input  logic                       camVsync,
  input  logic [`CAM_DATA_WIDTH-1:0] camData,
  input  logic                       captureEnable,
  output logic                       camnReset,
  output logic [`WORD_WIDTH-1:0]     grayWord,
  output logic                       grayWordValid,
  output logic                       overflow
);

  import camPkg::*;

  pixelEntry_t s_pushEntry;
  pixelEntry_t s_popEntry;
  logic        s_push;
  logic        s_pop;
  logic        s_notEmpty;

  cameraCapture capture (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .camPclk(camPclk),
    .camHsync(camHsync),
    .camVsync(camVsync),
    .camData(camData),
    .camnReset(camnReset),
    .push(s_push),
    .pushEntry(s_pushEntry)
  );

  pixelFifo #(
    .payload_t(pixelEntry_t)
  ) buffer (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .push(s_push),
    .pushEntry(s_pushEntry),
    .pop(s_pop),
    .popEntry(s_popEntry),
    .notEmpty(s_notEmpty),
    .overflow(overflow)
  );

  grayscalePacker packer (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .notEmpty(s_notEmpty),
    .popEntry(s_popEntry),
    .captureEnable(captureEnable),
    .pop(s_pop),
    .grayWord(grayWord),
    .grayWordValid(grayWordValid)
  );

endmodule

/* camPkg.sv */
package camPkg;

  // one camera pixel with red in the top bits
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // the frame-start flag marks the first pixel after a vertical sync
  typedef struct packed {
    logic    frameStart;
    rgb565_t pixel;
  } pixelEntry_t;

endpackage

/* cam_defines.svh */
`ifndef CAM_DEFINES_SVH
`define CAM_DEFINES_SVH

`define CAM_DATA_WIDTH 8
`define RGB_WIDTH 16
`define GRAY_WIDTH 8
`define WORD_WIDTH 32
`define PIXELS_PER_WORD 4
`define FIFO_DEPTH 8

// top bit of the counter releases the camera
`define RESET_COUNT_BITS 5
`define SYNC_STAGES 2

`endif

/* cameraCapture.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module cameraCapture (
  input  logic                       s_systemClock,
  input  logic                       s_pllLocked,
  input  logic                       camPclk,
  input  logic                       camHsync,
  input  logic                       camVsync,
  input  logic [`CAM_DATA_WIDTH-1:0] camData,
  output logic                       camnReset,
  output logic                       push,
  output camPkg::pixelEntry_t        pushEntry
);

  import camPkg::*;

  logic [`RESET_COUNT_BITS-1:0] s_resetCountReg;
  logic [`SYNC_STAGES-1:0]      s_pclkSync;
  logic [`SYNC_STAGES-1:0]      s_hsyncSync;
  logic [`SYNC_STAGES-1:0]      s_vsyncSync;
  logic [`CAM_DATA_WIDTH-1:0]   s_dataSync [`SYNC_STAGES];
  logic                         s_pclkLastReg;
  logic                         s_vsyncLastReg;
  logic                         s_pclkRise;
  logic                         s_vsyncRise;
  logic                         s_sampleByte;
  logic                         s_lowPhaseReg;
  logic                         s_frameStartPendingReg;
  logic [`CAM_DATA_WIDTH-1:0]   s_highByteReg;
  logic [`RGB_WIDTH-1:0]        s_pixelBits;

  // *********************************************************
  // camera reset follows the PLL lock
  assign camnReset = s_resetCountReg[`RESET_COUNT_BITS-1];

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!camnReset) begin
      s_resetCountReg <= s_resetCountReg + `RESET_COUNT_BITS'(1);
    end
  end

  // *********************************************************
  // pclk is only sampled here and never clocks anything
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_pclkSync     <= '0;
      s_hsyncSync    <= '0;
      s_vsyncSync    <= '0;
      s_pclkLastReg  <= 1'b0;
      s_vsyncLastReg <= 1'b0;
    end else begin
      s_pclkSync     <= {s_pclkSync[`SYNC_STAGES-2:0], camPclk};
      s_hsyncSync    <= {s_hsyncSync[`SYNC_STAGES-2:0], camHsync};
      s_vsyncSync    <= {s_vsyncSync[`SYNC_STAGES-2:0], camVsync};
      s_pclkLastReg  <= s_pclkSync[`SYNC_STAGES-1];
      s_vsyncLastReg <= s_vsyncSync[`SYNC_STAGES-1];
    end
  end

  always_ff @(posedge s_systemClock) begin
    s_dataSync[0] <= camData;
    for (int i = 1; i < `SYNC_STAGES; i++) begin
      s_dataSync[i] <= s_dataSync[i-1];
    end
  end

  assign s_pclkRise   = s_pclkSync[`SYNC_STAGES-1] & ~s_pclkLastReg;
  assign s_vsyncRise  = camnReset & s_vsyncSync[`SYNC_STAGES-1] & ~s_vsyncLastReg;
  assign s_sampleByte = camnReset & s_pclkRise & s_hsyncSync[`SYNC_STAGES-1] &
                        ~s_vsyncSync[`SYNC_STAGES-1];
  assign s_pixelBits  = {s_highByteReg, s_dataSync[`SYNC_STAGES-1]};

  // *********************************************************
  // high byte comes first, the low byte completes the pixel
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_lowPhaseReg          <= 1'b0;
      s_frameStartPendingReg <= 1'b0;
      push                   <= 1'b0;
    end else begin
      push <= 1'b0;
      if (s_vsyncRise) begin
        s_lowPhaseReg          <= 1'b0;
        s_frameStartPendingReg <= 1'b1;
      end else if (s_sampleByte) begin
        s_lowPhaseReg <= ~s_lowPhaseReg;
        if (s_lowPhaseReg) begin
          push                   <= 1'b1;
          s_frameStartPendingReg <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (s_sampleByte && !s_lowPhaseReg) begin
      s_highByteReg <= s_dataSync[`SYNC_STAGES-1];
    end
    if (s_sampleByte && s_lowPhaseReg) begin
      pushEntry.frameStart <= s_frameStartPendingReg;
      pushEntry.pixel      <= rgb565_t'(s_pixelBits);
    end
  end

endmodule

/* camera_golden.txt */
// all values hex; first value is the number of frames
// frame: test mode(1 enabled, 0 held low) pixels words overflow, RGB565 pixels, expected words
05
// test 2: capture enabled, two full words
02 1 08 02 0
FFFF 0000 F800 07E0 001F 8410 FFE0 07FF
954C00FF B2E2821C
// test 3: six pixels leave a partial word
03 1 06 01 0
F81F 4208 C618 FFFF 0000 F800
FFC44169
// test 3: the next frame starts again at byte 0
03 1 04 01 0
07E0 001F 8410 4208
41821C95
// test 4: capture held low, the last four pixels are dropped
04 0 0C 02 1
C618 F81F 07FF FFE0 8410 4208 0000 FFFF F800 07E0 001F F81F
E2B269C4 FF004182
// test 5: a frame start clears the overflow flag
05 1 08 02 0
4208 C618 F800 001F 07E0 FFFF 8410 07FF
1C4CC441 B282FF95

/* filelist.f */
+incdir+.
camPkg.sv
cameraCapture.sv
pixelFifo.sv
grayscalePacker.sv
camGrayTop.sv
camGrayAssertions.sv
camGrayTb.sv

/* grayscalePacker.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module grayscalePacker (
  input  logic                   s_systemClock,
  input  logic                   s_pllLocked,
  input  logic                   notEmpty,
  input  camPkg::pixelEntry_t    popEntry,
  input  logic                   captureEnable,
  output logic                   pop,
  output logic [`WORD_WIDTH-1:0] grayWord,
  output logic                   grayWordValid
);

  import camPkg::*;

  localparam int INDEX_BITS = $clog2(`PIXELS_PER_WORD);
  localparam logic [INDEX_BITS-1:0] LAST_INDEX = INDEX_BITS'(`PIXELS_PER_WORD - 1);

  rgb565_t                s_pixel;
  logic [7:0]             s_red8;
  logic [7:0]             s_green8;
  logic [7:0]             s_blue8;
  logic [15:0]            s_weightedSum;
  logic [`GRAY_WIDTH-1:0] s_gray;
  logic [INDEX_BITS-1:0]  s_byteIndex;
  logic [INDEX_BITS-1:0]  s_byteIndexReg;

  assign pop     = notEmpty & captureEnable;
  assign s_pixel = popEntry.pixel;

  // *********************************************************
  // widen each field to 8 bits by repeating its top bits
  assign s_red8   = {s_pixel.red, s_pixel.red[4:2]};
  assign s_green8 = {s_pixel.green, s_pixel.green[5:4]};
  assign s_blue8  = {s_pixel.blue, s_pixel.blue[4:2]};

  // weights sum to 256 so the top byte is the gray value
  assign s_weightedSum = 16'd77 * {8'd0, s_red8} +
                         16'd150 * {8'd0, s_green8} +
                         16'd29 * {8'd0, s_blue8};
  assign s_gray        = s_weightedSum[15:8];

  // a frame start throws away the partial word
  assign s_byteIndex = popEntry.frameStart ? '0 : s_byteIndexReg;

  // *********************************************************
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_byteIndexReg <= '0;
      grayWordValid  <= 1'b0;
    end else begin
      grayWordValid <= 1'b0;
      if (pop) begin
        if (s_byteIndex == LAST_INDEX) begin
          grayWordValid  <= 1'b1;
          s_byteIndexReg <= '0;
        end else begin
          s_byteIndexReg <= s_byteIndex + INDEX_BITS'(1);
        end
      end
    end
  end

  // byte 0 sits in the low bits of the word
  always_ff @(posedge s_systemClock) begin
    if (pop) begin
      grayWord[s_byteIndex * `GRAY_WIDTH +: `GRAY_WIDTH] <= s_gray;
    end
  end

endmodule

/* pixelFifo.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module pixelFifo #(
  parameter type payload_t = camPkg::pixelEntry_t
) (
  input  logic     s_systemClock,
  input  logic     s_pllLocked,
  input  logic     push,
  input  payload_t pushEntry,
  input  logic     pop,
  output payload_t popEntry,
  output logic     notEmpty,
  output logic     overflow
);

  localparam int PTR_BITS   = $clog2(`FIFO_DEPTH);
  localparam int COUNT_BITS = $clog2(`FIFO_DEPTH + 1);
  localparam logic [PTR_BITS-1:0]   LAST_PTR   = PTR_BITS'(`FIFO_DEPTH - 1);
  localparam logic [COUNT_BITS-1:0] FULL_COUNT = COUNT_BITS'(`FIFO_DEPTH);

  payload_t              s_memory [`FIFO_DEPTH];
  logic [PTR_BITS-1:0]   s_writePtrReg;
  logic [PTR_BITS-1:0]   s_readPtrReg;
  logic [COUNT_BITS-1:0] s_countReg;
  logic                  s_full;
  logic                  s_write;

  assign s_full   = (s_countReg == FULL_COUNT);
  assign s_write  = push & ~s_full;
  assign notEmpty = (s_countReg != '0);
  assign popEntry = s_memory[s_readPtrReg];

  always_ff @(posedge s_systemClock) begin
    if (s_write) begin
      s_memory[s_writePtrReg] <= pushEntry;
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_writePtrReg <= '0;
      s_readPtrReg  <= '0;
      s_countReg    <= '0;
      overflow      <= 1'b0;
    end else begin
      if (s_write) begin
        s_writePtrReg <= (s_writePtrReg == LAST_PTR) ? '0 : s_writePtrReg + PTR_BITS'(1);
      end
      if (pop) begin
        s_readPtrReg <= (s_readPtrReg == LAST_PTR) ? '0 : s_readPtrReg + PTR_BITS'(1);
      end
      case ({s_write, pop})
        2'b10:   s_countReg <= s_countReg + COUNT_BITS'(1);
        2'b01:   s_countReg <= s_countReg - COUNT_BITS'(1);
        default: s_countReg <= s_countReg;
      endcase
      // a new frame starts clean even when its first pixel finds no room
      if (push && pushEntry.frameStart) begin
        overflow <= 1'b0;
      end else if (push && s_full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module camGrayTb -f filelist.f -o camGrayTb
./obj_dir/camGrayTb 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0
